//--- gemac_tx.f
source/gemac_frame_pkg.sv
source/gmii_pkg.sv
source/tx_ctrl_if.sv
source/gemac_tx_fsm.sv
source/tx_frame_timers.sv
source/pause_frame_gen.sv
source/crc32_d8.sv
source/gmii_tx_out.sv
source/gemac_tx.sv
tb/gemac_tx_checker.sv
tb/gemac_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the gemac_tx testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module gemac_tx_tb -f gemac_tx.f -o gemac_tx_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/gemac_tx_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi
exit 0

//--- source/crc32_d8.sv
module crc32_d8
   import gmii_pkg::*;
(
   input logic tx_clk,
   input logic clear,
   input logic enable,
   input gmii_byte_t data,
   output logic [31:0] crc
);
   logic [31:0] crc_reg;

   function automatic logic [31:0] crc_step(input logic [31:0] c, input gmii_byte_t d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++)
         r = (r[0] ^ d[i]) ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);   // reflected 04C11DB7
      return r;
   endfunction

   always_ff @(posedge tx_clk)
   begin
      if (clear)
         crc_reg <= '1;
      else if (enable)
         crc_reg <= crc_step(crc_reg, data);
   end

   assign crc = ~crc_reg;
endmodule

//--- source/gemac_frame_pkg.sv
package gemac_frame_pkg;
   localparam int preamble_len = 7;
   localparam int min_body_len = 60;       // header plus payload, FCS excluded
   localparam int fcs_len = 4;
   localparam int reset_gap = 100;
   localparam int pause_hdr_len = 18;

   localparam logic [47:0] flow_ctrl_addr = 48'h01_80_C2_00_00_01;
   localparam logic [15:0] mac_ctrl_type = 16'h8808;
   localparam logic [15:0] pause_opcode = 16'h0001;

   typedef enum logic [7:0] {
      idle,
      preamble,
      sfd,
      in_frame,
      in_frame_2,                           // min length met, no more padding
      pad,
      fcs,
      error,
      pause_pre,
      pause_sfd,
      pause_hdr
   } tx_state_t;
endpackage

//--- source/gemac_tx.sv
module gemac_tx (
   input logic tx_clk,
   input logic reset,
   input logic [7:0] tx_data,
   input logic tx_valid,
   input logic tx_error,
   input logic [7:0] ifg,
   input logic [47:0] mac_addr,
   input logic pause_req,
   input logic [15:0] pause_time,
   output logic tx_ack,
   output logic gmii_tx_en,
   output logic gmii_tx_er,
   output logic [7:0] gmii_txd
);
   logic min_len_reached;
   logic gap_done;
   logic pause_pending;
   logic pause_start;
   logic [7:0] pause_byte;

   tx_ctrl_if ctrl_if (.tx_clk(tx_clk));

   gemac_tx_fsm fsm0 (
      .tx_clk(tx_clk),
      .reset(reset),
      .tx_valid(tx_valid),
      .tx_error(tx_error),
      .min_len_reached(min_len_reached),
      .gap_done(gap_done),
      .pause_pending(pause_pending),
      .tx_ack(tx_ack),
      .pause_start(pause_start),
      .ctrl(ctrl_if.fsm_mp)
   );

   tx_frame_timers timers0 (
      .tx_clk(tx_clk),
      .reset(reset),
      .ifg(ifg),
      .ctrl(ctrl_if.timer_mp),
      .min_len_reached(min_len_reached),
      .gap_done(gap_done)
   );

   pause_frame_gen pause0 (
      .tx_clk(tx_clk),
      .reset(reset),
      .pause_req(pause_req),
      .pause_time(pause_time),
      .mac_addr(mac_addr),
      .pause_start(pause_start),
      .ctrl(ctrl_if.pause_mp),
      .pause_pending(pause_pending),
      .pause_byte(pause_byte)
   );

   gmii_tx_out out0 (
      .tx_clk(tx_clk),
      .reset(reset),
      .tx_data(tx_data),
      .pause_byte(pause_byte),
      .ctrl(ctrl_if.out_mp),
      .gmii_tx_en(gmii_tx_en),
      .gmii_tx_er(gmii_tx_er),
      .gmii_txd(gmii_txd)
   );
endmodule

//--- source/gemac_tx_fsm.sv
module gemac_tx_fsm
   import gemac_frame_pkg::*, gmii_pkg::*;
(
   input logic tx_clk,
   input logic reset,
   input logic tx_valid,
   input logic tx_error,
   input logic min_len_reached,
   input logic gap_done,
   input logic pause_pending,
   output logic tx_ack,
   output logic pause_start,
   tx_ctrl_if.fsm_mp ctrl
);
   tx_state_t state;
   logic [4:0] idx;

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         state <= idle;
         idx <= '0;
      end
      else
      begin
         case (state)
            idle:
               if (gap_done && pause_pending)
                  state <= pause_pre;                // pause wins over data
               else if (gap_done && tx_valid)
                  state <= preamble;
            preamble, pause_pre:
               if (idx == 5'(preamble_len - 1))
               begin
                  state <= (state == preamble) ? sfd : pause_sfd;
                  idx <= '0;
               end
               else
                  idx <= idx + 5'd1;
            sfd:
               state <= in_frame;
            in_frame, in_frame_2:
               if (tx_error)
                  state <= error;                    // client underrun
               else if (!tx_valid && min_len_reached)
               begin
                  state <= fcs;
                  idx <= 5'd1;                       // fcs byte 0 already selected
               end
               else if (!tx_valid)
                  state <= pad;
               else if (min_len_reached)
                  state <= in_frame_2;
            pad:
               if (min_len_reached)
               begin
                  state <= fcs;
                  idx <= 5'd1;
               end
            fcs:
               if (idx == 5'(fcs_len - 1))
               begin
                  state <= idle;
                  idx <= '0;
               end
               else
                  idx <= idx + 5'd1;
            error:
               state <= idle;
            pause_sfd:
            begin
               state <= pause_hdr;
               idx <= 5'd1;                          // header byte shows one step behind idx
            end
            pause_hdr:
               if (idx == 5'(pause_hdr_len))
               begin
                  state <= pad;
                  idx <= '0;
               end
               else
                  idx <= idx + 5'd1;
            default:
               state <= idle;
         endcase
      end
   end

   // next GMII byte source and control levels
   always_comb
   begin
      ctrl.sel = sel_idle;
      ctrl.tx_en = 1'b1;
      ctrl.tx_er = 1'b0;
      tx_ack = 1'b0;
      case (state)
         preamble, pause_pre:
            ctrl.sel = sel_preamble;
         sfd, pause_sfd:
            ctrl.sel = sel_sfd;
         in_frame, in_frame_2:
         begin
            tx_ack = 1'b1;
            if (tx_valid || tx_error)
               ctrl.sel = sel_data;                  // errored byte still goes out
            else
               ctrl.sel = min_len_reached ? sel_fcs : sel_zero;
         end
         pad:
            ctrl.sel = min_len_reached ? sel_fcs : sel_zero;
         fcs:
            ctrl.sel = sel_fcs;
         error:
         begin
            ctrl.sel = sel_zero;
            ctrl.tx_er = 1'b1;
         end
         pause_hdr:
            ctrl.sel = sel_pause;
         default:
            ctrl.tx_en = 1'b0;                        // idle
      endcase
   end

   assign ctrl.byte_idx = idx;
   assign ctrl.crc_clear = (state == idle);
   assign ctrl.frame_done = (state == fcs) && (idx == 5'(fcs_len - 1));
   assign ctrl.in_frame = !(state inside {idle, preamble, pause_pre, error});
   assign pause_start = (state == idle) && gap_done && pause_pending;
endmodule

//--- source/gmii_pkg.sv
package gmii_pkg;
   typedef logic [7:0] gmii_byte_t;

   localparam gmii_byte_t gmii_preamble = 8'h55;
   localparam gmii_byte_t gmii_sfd = 8'hD5;

   typedef enum logic [2:0] {
      sel_idle,
      sel_preamble,
      sel_sfd,
      sel_data,
      sel_zero,
      sel_fcs,
      sel_pause
   } tx_byte_sel_t;
endpackage

//--- source/gmii_tx_out.sv
module gmii_tx_out
   import gmii_pkg::*;
(
   input logic tx_clk,
   input logic reset,
   input gmii_byte_t tx_data,
   input gmii_byte_t pause_byte,
   tx_ctrl_if.out_mp ctrl,
   output logic gmii_tx_en,
   output logic gmii_tx_er,
   output gmii_byte_t gmii_txd
);
   gmii_byte_t next_byte;
   logic [31:0] crc;
   logic crc_en;

   always_comb
   begin
      case (ctrl.sel)
         sel_preamble: next_byte = gmii_preamble;
         sel_sfd:      next_byte = gmii_sfd;
         sel_data:     next_byte = tx_data;
         sel_pause:    next_byte = pause_byte;
         sel_fcs:      next_byte = crc[{ctrl.byte_idx[1:0], 3'b000} +: 8];   // lsb first
         default:      next_byte = '0;
      endcase
   end

   assign crc_en = ctrl.sel inside {sel_data, sel_zero, sel_pause};

   crc32_d8 crc0 (
      .tx_clk(tx_clk),
      .clear(ctrl.crc_clear),
      .enable(crc_en),
      .data(next_byte),
      .crc(crc)
   );

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         gmii_tx_en <= 1'b0;
         gmii_tx_er <= 1'b0;
         gmii_txd <= '0;
      end
      else
      begin
         gmii_tx_en <= ctrl.tx_en;
         gmii_tx_er <= ctrl.tx_er;
         gmii_txd <= next_byte;
      end
   end
endmodule

//--- source/pause_frame_gen.sv
module pause_frame_gen
   import gemac_frame_pkg::*, gmii_pkg::*;
(
   input logic tx_clk,
   input logic reset,
   input logic pause_req,
   input logic [15:0] pause_time,
   input logic [47:0] mac_addr,
   input logic pause_start,
   tx_ctrl_if.pause_mp ctrl,
   output logic pause_pending,
   output gmii_byte_t pause_byte
);
   logic [15:0] pause_time_held;
   logic [8*pause_hdr_len-1:0] hdr;

   // destination first, pause time last
   assign hdr = {flow_ctrl_addr, mac_addr, mac_ctrl_type, pause_opcode, pause_time_held};

   always_ff @(posedge tx_clk)
   begin
      if (reset)
         pause_pending <= 1'b0;
      else if (pause_req)
         pause_pending <= 1'b1;              // a new request is kept
      else if (pause_start)
         pause_pending <= 1'b0;
   end

   always_ff @(posedge tx_clk)
   begin
      if (pause_req)
         pause_time_held <= pause_time;
   end

   // used in the following cycle
   always_ff @(posedge tx_clk)
   begin
      if (ctrl.byte_idx < 5'(pause_hdr_len))
         pause_byte <= hdr[8*(pause_hdr_len - 1 - ctrl.byte_idx) +: 8];
      else
         pause_byte <= '0;
   end
endmodule

//--- source/tx_ctrl_if.sv
interface tx_ctrl_if
   import gmii_pkg::*;
(
   input logic tx_clk
);
   tx_byte_sel_t sel;
   logic tx_en;
   logic tx_er;
   logic crc_clear;
   logic [4:0] byte_idx;                    // step within preamble, header or FCS
   logic frame_done;
   logic in_frame;

   modport fsm_mp (input tx_clk,
                   output sel, tx_en, tx_er, crc_clear, byte_idx, frame_done, in_frame);
   modport timer_mp (input tx_clk, in_frame, frame_done);
   modport out_mp (input tx_clk, sel, tx_en, tx_er, crc_clear, byte_idx);
   modport pause_mp (input tx_clk, byte_idx);
endinterface

//--- source/tx_frame_timers.sv
module tx_frame_timers
   import gemac_frame_pkg::*;
(
   input logic tx_clk,
   input logic reset,
   input logic [7:0] ifg,
   tx_ctrl_if.timer_mp ctrl,
   output logic min_len_reached,
   output logic gap_done
);
   logic [6:0] byte_cnt;                     // delimiter is counted too
   logic [7:0] gap_cnt;

   always_ff @(posedge tx_clk)
   begin
      if (reset || !ctrl.in_frame)
         byte_cnt <= '0;
      else if (!min_len_reached)
         byte_cnt <= byte_cnt + 7'd1;        // holds once reached
   end

   assign min_len_reached = (byte_cnt == 7'(min_body_len + 1));

   always_ff @(posedge tx_clk)
   begin
      if (reset)
         gap_cnt <= 8'(reset_gap);
      else if (ctrl.frame_done)
         gap_cnt <= ifg;
      else if (gap_cnt != '0)
         gap_cnt <= gap_cnt - 8'd1;
   end

   assign gap_done = (gap_cnt == '0);
endmodule

//--- tb/gemac_tx_checker.sv
module gemac_tx_checker
   import gemac_frame_pkg::*, gmii_pkg::*;
(
   input logic tx_clk,
   input logic reset,
   input logic tx_ack,
   input logic gmii_tx_en,
   input logic gmii_tx_er,
   input logic frame_done,
   input logic [7:0] ifg
);
   timeunit 1ns;
   timeprecision 1ps;

   logic done_q;                          // last FCS byte is on GMII
   logic [7:0] quiet_cnt;                 // idle cycles still owed

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         done_q <= 1'b0;
         quiet_cnt <= '0;
      end
      else
      begin
         done_q <= frame_done;
         if (done_q)
            quiet_cnt <= ifg;
         else if (quiet_cnt != '0)
            quiet_cnt <= quiet_cnt - 8'd1;
      end
   end

   er_inside_frame: assert property (@(posedge tx_clk) disable iff (reset)
      gmii_tx_er |-> gmii_tx_en)
      else $error("gmii_tx_er is high while gmii_tx_en is low");

   no_ack_in_reset: assert property (@(posedge tx_clk) reset |-> !tx_ack)
      else $error("tx_ack is high during reset");

   gap_after_frame: assert property (@(posedge tx_clk) disable iff (reset)
      (quiet_cnt != '0) |-> !gmii_tx_en)
      else $error("gmii_tx_en rose inside the inter-frame gap");
endmodule

bind gemac_tx gemac_tx_checker chk0 (
   .tx_clk(tx_clk),
   .reset(reset),
   .tx_ack(tx_ack),
   .gmii_tx_en(gmii_tx_en),
   .gmii_tx_er(gmii_tx_er),
   .frame_done(ctrl_if.frame_done),
   .ifg(ifg)
);

//--- tb/gemac_tx_tb.sv
module gemac_tx_tb
   import gemac_frame_pkg::*, gmii_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   typedef enum logic [1:0] {k_data, k_pause, k_abort} row_kind_t;

   typedef struct packed {
      row_kind_t kind;
      int len;                            // bytes the client offers
      int ifg;
      logic [15:0] ptime;
      int abort_at;                       // payload byte sent with tx_error
      int exp_body;                       // bytes between delimiter and FCS
   } row_t;

   localparam int n_rows = 6;
   localparam int wait_limit = 400;
   localparam logic [47:0] station_addr = 48'h02_1A_2B_3C_4D_5E;

   row_t rows [n_rows] = '{
      '{k_data, 100, 12, 16'h0000, -1, 100},
      '{k_data, 10, 40, 16'h0000, -1, 60},
      '{k_pause, 0, 12, 16'h1234, -1, 60},
      '{k_pause, 30, 40, 16'hBEEF, -1, 60},   // pause pending while data waits
      '{k_abort, 40, 12, 16'h0000, 20, 22},
      '{k_data, 60, 40, 16'h0000, -1, 60}
   };

   logic tx_clk = 1'b0;
   logic reset;
   gmii_byte_t tx_data;
   logic tx_valid;
   logic tx_error;
   logic [7:0] ifg;
   logic [47:0] mac_addr;
   logic pause_req;
   logic [15:0] pause_time;
   logic tx_ack;
   logic gmii_tx_en;
   logic gmii_tx_er;
   gmii_byte_t gmii_txd;

   gmii_byte_t pay[$];
   gmii_byte_t exp_bytes[$];
   int exp_er_at;
   gmii_byte_t rx_byte[$];
   logic rx_er[$];
   int fr_start[$];
   int fr_len[$];
   int fr_gap[$];
   int idle_run;
   bit in_mon;
   int min_gap;

   always #20 tx_clk = ~tx_clk;

   gemac_tx dut0 (
      .tx_clk(tx_clk),
      .reset(reset),
      .tx_data(tx_data),
      .tx_valid(tx_valid),
      .tx_error(tx_error),
      .ifg(ifg),
      .mac_addr(mac_addr),
      .pause_req(pause_req),
      .pause_time(pause_time),
      .tx_ack(tx_ack),
      .gmii_tx_en(gmii_tx_en),
      .gmii_tx_er(gmii_tx_er),
      .gmii_txd(gmii_txd)
   );

   // collects GMII frames at mid-cycle
   always @(negedge tx_clk)
   begin
      if (reset)
         idle_run = 0;
      else if (gmii_tx_en)
      begin
         if (!in_mon)
         begin
            fr_start.push_back(rx_byte.size());
            fr_gap.push_back(idle_run);
            in_mon = 1'b1;
         end
         rx_byte.push_back(gmii_txd);
         rx_er.push_back(gmii_tx_er);
      end
      else
      begin
         if (in_mon)
         begin
            fr_len.push_back(rx_byte.size() - fr_start[fr_start.size() - 1]);
            in_mon = 1'b0;
            idle_run = 0;
         end
         idle_run++;
      end
   end

   task automatic fail_run();
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_byte(input string name, input gmii_byte_t got, input gmii_byte_t want);
      if (got !== want)
      begin
         $display("FAIL time %0d ns: %s = %02h, expected %02h", $time, name, got, want);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want)
      begin
         $display("FAIL time %0d ns: %s = %b, expected %b", $time, name, got, want);
         fail_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int want);
      if (got != want)
      begin
         $display("FAIL time %0d ns: %s = %0d, expected %0d", $time, name, got, want);
         fail_run();
      end
   endtask

   task automatic check_gap(input int idle, input int min_idle);
      if (idle < min_idle)
      begin
         $display("FAIL time %0d ns: idle gap before gmii_tx_en = %0d, expected at least %0d",
                  $time, idle, min_idle);
         fail_run();
      end
   endtask

   // MSB-first CRC-32 over bit-reversed bytes with the result reflected and complemented
   function automatic logic [31:0] frame_fcs(input int first);
      logic [31:0] c;
      logic [31:0] r;
      logic fb;
      c = 32'hFFFF_FFFF;
      for (int i = first; i < exp_bytes.size(); i++)
         for (int b = 0; b < 8; b++)
         begin
            fb = c[31] ^ exp_bytes[i][b];
            c = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
         end
      r = {<<{c}};
      return ~r;
   endfunction

   task automatic build_expected(input row_kind_t kind, input int abort_at,
                                 input logic [15:0] ptime);
      logic [31:0] fcs;
      exp_bytes.delete();
      exp_er_at = -1;
      repeat (preamble_len) exp_bytes.push_back(gmii_preamble);
      exp_bytes.push_back(gmii_sfd);
      if (kind == k_pause)
      begin
         for (int i = 5; i >= 0; i--)
            exp_bytes.push_back(flow_ctrl_addr[8*i +: 8]);
         for (int i = 5; i >= 0; i--)
            exp_bytes.push_back(station_addr[8*i +: 8]);
         exp_bytes.push_back(mac_ctrl_type[15:8]);
         exp_bytes.push_back(mac_ctrl_type[7:0]);
         exp_bytes.push_back(pause_opcode[15:8]);
         exp_bytes.push_back(pause_opcode[7:0]);
         exp_bytes.push_back(ptime[15:8]);
         exp_bytes.push_back(ptime[7:0]);
      end
      else if (kind == k_abort)
      begin
         for (int i = 0; i <= abort_at; i++)
            exp_bytes.push_back(pay[i]);
         exp_er_at = exp_bytes.size();
         exp_bytes.push_back(8'h00);         // error cycle and no FCS
         return;
      end
      else
         foreach (pay[i])
            exp_bytes.push_back(pay[i]);
      while (exp_bytes.size() < preamble_len + 1 + min_body_len)
         exp_bytes.push_back(8'h00);
      fcs = frame_fcs(preamble_len + 1);
      for (int k = 0; k < fcs_len; k++)
         exp_bytes.push_back(fcs[8*k +: 8]);
   endtask

   task automatic check_frame(input int f, input int body, input bit has_fcs);
      int s;
      s = fr_start[f];
      check_count($sformatf("length of frame %0d", f), fr_len[f],
                  preamble_len + 1 + body + (has_fcs ? fcs_len : 0));
      for (int j = 0; j < exp_bytes.size(); j++)
      begin
         check_byte($sformatf("gmii_txd byte %0d of frame %0d", j, f), rx_byte[s + j],
                    exp_bytes[j]);
         check_bit($sformatf("gmii_tx_er byte %0d of frame %0d", j, f), rx_er[s + j],
                   j == exp_er_at);
      end
      check_gap(fr_gap[f], min_gap);
   endtask

   task automatic wait_frames(input int count);
      int cycles;
      cycles = 0;
      while (fr_len.size() < count)
      begin
         @(posedge tx_clk);
         cycles++;
         if (cycles > wait_limit)
         begin
            $display("no complete GMII frame arrived within %0d cycles", wait_limit);
            fail_run();
         end
      end
   endtask

   // client side sends one byte per acknowledged cycle
   task automatic drive_payload(input int len, input int abort_at);
      int i;
      int cycles;
      int acks;
      logic ack;
      bit done;
      i = 0;
      cycles = 0;
      acks = 0;
      done = 1'b0;
      tx_valid = 1'b1;
      tx_data = pay[0];
      tx_error = (abort_at == 0);
      while (!done)
      begin
         @(negedge tx_clk);
         ack = tx_ack;
         @(posedge tx_clk);
         #2;
         cycles++;
         if (cycles > wait_limit)
         begin
            $display("client payload was not taken within %0d cycles", wait_limit);
            fail_run();
         end
         if (ack)
            acks++;
         if (ack && (!tx_valid || tx_error))
         begin
            tx_valid = 1'b0;                  // payload ended or frame aborted
            tx_error = 1'b0;
            tx_data = '0;
            done = 1'b1;
         end
         else if (ack)
         begin
            i++;
            tx_valid = (i < len);
            tx_data = (i < len) ? pay[i] : 8'h00;
            tx_error = (i == abort_at);
         end
      end
      // one ack per byte plus the ending cycle, or up to the aborted byte
      check_count("tx_ack cycles", acks, (abort_at >= 0) ? abort_at + 1 : len + 1);
   endtask

   initial
   begin
      int nframes;
      void'($urandom(39235));
      reset = 1'b1;
      tx_data = '0;
      tx_valid = 1'b0;
      tx_error = 1'b0;
      ifg = 8'd12;
      mac_addr = station_addr;
      pause_req = 1'b0;
      pause_time = '0;
      exp_er_at = -1;
      min_gap = reset_gap;
      nframes = 0;
      repeat (10) @(posedge tx_clk);
      #2;
      reset = 1'b0;
      for (int r = 0; r < n_rows; r++)
      begin
         pay.delete();
         for (int i = 0; i < rows[r].len; i++)
            pay.push_back(gmii_byte_t'($urandom));
         @(posedge tx_clk);
         #2;
         ifg = 8'(rows[r].ifg);
         pause_time = rows[r].ptime;
         pause_req = (rows[r].kind == k_pause);
         @(posedge tx_clk);
         #2;
         pause_req = 1'b0;
         if (rows[r].len > 0)
            drive_payload(rows[r].len, (rows[r].kind == k_abort) ? rows[r].abort_at : -1);
         if (rows[r].kind == k_pause)
         begin
            wait_frames(nframes + 1);
            build_expected(k_pause, -1, rows[r].ptime);
            check_frame(nframes, rows[r].exp_body, 1'b1);
            min_gap = rows[r].ifg;
            nframes++;
         end
         if (rows[r].len > 0)
         begin
            wait_frames(nframes + 1);
            build_expected((rows[r].kind == k_abort) ? k_abort : k_data, rows[r].abort_at,
                           16'h0000);
            check_frame(nframes, rows[r].exp_body, rows[r].kind != k_abort);
            min_gap = (rows[r].kind == k_abort) ? 0 : rows[r].ifg;
            nframes++;
         end
      end
      repeat (50) @(posedge tx_clk);          // last gap still under the bound checks
      $display("Test passed");
      $finish;
   end
endmodule
